/* flist.f */
verilog/cpu_types_pkg.sv
verilog/cache_types_pkg.sv
verilog/cache_ram.sv
verilog/tag_lookup.sv
verilog/dcache_ctrl.sv
verilog/dcache.sv
testbench/clock_gen.sv
testbench/dcache_properties.sv
testbench/dcache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the dcache testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb \
	-f flist.f -Mdir obj_dir -o dcache_sim > build.log 2>&1 &&
	obj_dir/dcache_sim > sim.log 2>&1 &&
	cat sim.log &&
	! grep -q "Test FAILED" sim.log ||
	{ cat build.log sim.log 2>/dev/null; echo "simulation failed"; exit 1; }
echo "simulation passed"

/* testbench/dcache_tb.sv */
// testbench for the two-way write-back data cache
// memory model with random wait states, a table of core requests,
// a reference copy of memory to predict loads and write-backs
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
	import cpu_types_pkg::*;
	import cache_types_pkg::*;
();

	localparam int RESET_WAIT = 40;
	localparam int DHIT_WAIT  = 100;
	localparam int FLUSH_WAIT = 1000;

	typedef enum logic [1:0] {
		OP_READ,
		OP_WRITE,
		OP_HALT
	} op_t;

	// request and the memory traffic it should cause
	typedef struct packed {
		op_t         op;
		addr_t       addr;
		word_t       store;
		logic [3:0]  reads;
		logic [1:0]  nwb;
		addr_t [2:0] wb;
	} row_t;

	logic      CLK;
	logic      nRST;
	cpu_req_t  cpu_req;
	cpu_resp_t cpu_resp;
	mem_req_t  mem_req;
	mem_resp_t mem_resp;

	word_t model_mem [addr_t];
	word_t ref_mem [addr_t];
	addr_t wr_log [$];
	int    rd_count;
	row_t  rows [$];
	int    errors;
	int    tests;
	bit    timed_out;

	clock_gen #(
		.PERIOD_NS    (10),
		.RESET_CYCLES (10)
	) u_clk (
		.CLK  (CLK),
		.nRST (nRST)
	);

	dcache dut0 (
		.CLK      (CLK),
		.nRST     (nRST),
		.cpu_req  (cpu_req),
		.cpu_resp (cpu_resp),
		.mem_req  (mem_req),
		.mem_resp (mem_resp)
	);

	// preload pattern that mixes every address bit
	function automatic word_t fill_word(addr_t a);
		return a ^ {a[18:0], a[31:19]} ^ 32'h3c5a0f96;
	endfunction

	function automatic word_t mem_word(addr_t a);
		return model_mem.exists(a) ? model_mem[a] : fill_word(a);
	endfunction

	function automatic word_t ref_word(addr_t a);
		return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
	endfunction

	function automatic addr_t word_addr(int tag, int index, int off);
		dcache_addr_t a;
		a        = '0;
		a.tag    = TAG_W'(tag);
		a.index  = INDEX_W'(index);
		a.blkoff = 1'(off);
		return a;
	endfunction

	function automatic string op_name(op_t op);
		case (op)
			OP_READ:  return "read";
			OP_WRITE: return "write";
			default:  return "halt";
		endcase
	endfunction

	function automatic void add_row(op_t op, addr_t addr, word_t store, int reads, int nwb,
			addr_t wb0 = '0, addr_t wb1 = '0, addr_t wb2 = '0);
		row_t r;
		r.op    = op;
		r.addr  = addr;
		r.store = store;
		r.reads = 4'(reads);
		r.nwb   = 2'(nwb);
		r.wb[0] = wb0;
		r.wb[1] = wb1;
		r.wb[2] = wb2;
		rows.push_back(r);
	endfunction

	// set 1 covers miss, hit, write and dirty eviction; set 2 the LRU order
	function automatic void build_table();
		add_row(OP_READ,  word_addr(1, 1, 0), '0, 2, 0);
		add_row(OP_READ,  word_addr(1, 1, 1), '0, 0, 0);
		add_row(OP_WRITE, word_addr(1, 1, 0), 32'ha5a50101, 0, 0);
		add_row(OP_READ,  word_addr(1, 1, 0), '0, 0, 0);
		add_row(OP_READ,  word_addr(1, 1, 1), '0, 0, 0);
		add_row(OP_READ,  word_addr(2, 1, 0), '0, 2, 0);
		add_row(OP_READ,  word_addr(3, 1, 1), '0, 2, 1, word_addr(1, 1, 0));
		add_row(OP_READ,  word_addr(1, 1, 0), '0, 2, 0);
		add_row(OP_WRITE, word_addr(4, 2, 0), 32'h5e000202, 2, 0);
		add_row(OP_WRITE, word_addr(5, 2, 1), 32'h5e000303, 2, 0);
		add_row(OP_READ,  word_addr(4, 2, 1), '0, 0, 0);
		add_row(OP_READ,  word_addr(6, 2, 0), '0, 2, 1, word_addr(5, 2, 0));
		add_row(OP_WRITE, word_addr(7, 3, 1), 32'h5e000404, 2, 0);
		add_row(OP_WRITE, word_addr(6, 2, 1), 32'h5e000505, 0, 0);
		// flush order is way 0 sets 0..7, then way 1
		add_row(OP_HALT, '0, '0, 0, 3, word_addr(4, 2, 0), word_addr(7, 3, 0),
			word_addr(6, 2, 0));
	endfunction

	// memory model with random wait states on every word
	initial begin : mem_model
		int wait_left;
		bit pending;
		wait_left      = 0;
		pending        = 1'b0;
		rd_count       = 0;
		mem_resp.dwait = 1'b1;
		mem_resp.load  = '0;
		void'($urandom(32'h4c298adf));
		forever begin
			@(negedge CLK);
			if (!(mem_req.ren || mem_req.wen)) begin
				mem_resp.dwait = 1'b1;
				pending        = 1'b0;
			end else begin
				if (!pending) begin
					pending   = 1'b1;
					wait_left = int'($urandom % 4);
				end
				if (wait_left > 0) begin
					mem_resp.dwait = 1'b1;
					wait_left--;
				end else begin
					// word is taken at the next rising edge
					mem_resp.dwait = 1'b0;
					pending        = 1'b0;
					if (mem_req.ren) begin
						mem_resp.load = mem_word(mem_req.addr);
						rd_count++;
					end else begin
						model_mem[mem_req.addr] = mem_req.store;
						wr_log.push_back(mem_req.addr);
					end
				end
			end
		end
	end

	task automatic wait_dhit(output bit ok);
		ok = 1'b0;
		for (int i = 0; i < DHIT_WAIT; i++) begin
			@(negedge CLK);
			if (cpu_resp.dhit) begin
				ok = 1'b1;
				break;
			end
		end
	endtask

	task automatic wait_flushed(output bit ok);
		ok = 1'b0;
		for (int i = 0; i < FLUSH_WAIT; i++) begin
			@(negedge CLK);
			if (cpu_resp.flushed) begin
				ok = 1'b1;
				break;
			end
		end
	endtask

	task automatic check_row(int n, row_t r, int rd_before, int wr_before);
		word_t exp;
		addr_t exp_addr;
		int    n_wr;
		n_wr = wr_log.size() - wr_before;
		if (r.op == OP_READ) begin
			exp = ref_word(r.addr);
			if (cpu_resp.load !== exp) begin
				$display("ERR %0t: row %0d load %h, expected %h", $time, n,
					cpu_resp.load, exp);
				errors++;
			end
		end
		if (r.op == OP_WRITE) begin
			ref_mem[r.addr] = r.store;
		end
		if (rd_count - rd_before != int'(r.reads)) begin
			$display("ERR %0t: row %0d made %0d memory reads, expected %0d", $time, n,
				rd_count - rd_before, r.reads);
			errors++;
		end
		if (n_wr != 2 * int'(r.nwb)) begin
			$display("ERR %0t: row %0d made %0d memory writes, expected %0d", $time, n,
				n_wr, 2 * r.nwb);
			errors++;
		end else begin
			for (int i = 0; i < n_wr; i++) begin
				exp_addr = r.wb[i / 2] | addr_t'((i % 2) * 4);
				if (wr_log[wr_before + i] !== exp_addr) begin
					$display("ERR %0t: row %0d write-back to %h, expected %h", $time, n,
						wr_log[wr_before + i], exp_addr);
					errors++;
				end
			end
		end
	endtask

	initial begin : stimulus
		row_t r;
		bit   ok;
		int   rd_before;
		int   wr_before;
		int   err_before;
		cpu_req   = '0;
		errors    = 0;
		tests     = 0;
		timed_out = 1'b0;
		build_table();

		for (int i = 0; i < RESET_WAIT && !nRST; i++) begin
			@(negedge CLK);
		end
		if (!nRST) begin
			$display("reset was never released");
			timed_out = 1'b1;
		end
		@(negedge CLK);

		for (int n = 0; n < rows.size() && !timed_out; n++) begin
			r          = rows[n];
			rd_before  = rd_count;
			wr_before  = wr_log.size();
			err_before = errors;
			cpu_req.ren   = (r.op == OP_READ);
			cpu_req.wen   = (r.op == OP_WRITE);
			cpu_req.halt  = (r.op == OP_HALT);
			cpu_req.addr  = r.addr;
			cpu_req.store = r.store;
			if (r.op == OP_HALT) begin
				wait_flushed(ok);
			end else begin
				wait_dhit(ok);
			end
			if (!ok) begin
				$display("row %0d (%s) timed out waiting for the cache to respond", n,
					op_name(r.op));
				timed_out = 1'b1;
			end else begin
				check_row(n, r, rd_before, wr_before);
				tests++;
				$display("row %0d %s %h: %s", n, op_name(r.op), r.addr,
					(errors == err_before) ? "ok" : "mismatch");
				// request stays up through the completing edge
				@(negedge CLK);
			end
		end

		// after the flush memory must hold every written word
		if (!timed_out) begin
			err_before = errors;
			foreach (ref_mem[a]) begin
				if (mem_word(a) !== ref_mem[a]) begin
					$display("ERR %0t: memory at %h is %h, expected %h", $time, a,
						mem_word(a), ref_mem[a]);
					errors++;
				end
			end
			// words written back unchanged keep their old value
			foreach (model_mem[a]) begin
				if (model_mem[a] !== ref_word(a)) begin
					$display("ERR %0t: memory at %h is %h, expected %h", $time, a,
						model_mem[a], ref_word(a));
					errors++;
				end
			end
			tests++;
			$display("memory compare: %s", (errors == err_before) ? "ok" : "mismatch");
		end

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0 && !timed_out) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/dcache_properties.sv */
// protocol assertions on the data cache controller
// bound into every dcache_ctrl instance
`timescale 1ns/1ps
`default_nettype none

module dcache_properties
	import cache_types_pkg::*;
(
	input logic      CLK,
	input logic      nRST,
	input cpu_req_t  req,
	input cpu_resp_t resp,
	input mem_req_t  mem_req,
	input mem_resp_t mem_resp
);

	a_mem_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
		!(mem_req.ren && mem_req.wen))
		else $error("memory read and write enables high together");

	a_hit_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
		resp.dhit |-> (req.ren || req.wen))
		else $error("dhit without a core request");

	a_flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
		resp.flushed |=> resp.flushed)
		else $error("flushed dropped before reset");

	// a stalled transfer must not move
	a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
		((mem_req.ren || mem_req.wen) && mem_resp.dwait) |=> $stable(mem_req))
		else $error("memory request changed while dwait high");

endmodule

bind dcache_ctrl dcache_properties u_props (
	.CLK      (CLK),
	.nRST     (nRST),
	.req      (req),
	.resp     (resp),
	.mem_req  (mem_req),
	.mem_resp (mem_resp)
);

`default_nettype wire

/* testbench/clock_gen.sv */
// clock and reset source for the dcache testbench
// free-running clock, reset held low for a set number of cycles
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 10
) (
	output logic CLK,
	output logic nRST
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD_NS / 2) CLK = ~CLK;
	end

	// released on a falling edge, away from the DUT's sampling edge
	initial begin
		nRST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;
	end

endmodule

`default_nettype wire

/* verilog/dcache.sv */
// two-way set associative write-back data cache
// controller, tag lookup and data array wired together
`timescale 1ns/1ps
`default_nettype none

module dcache
	import cpu_types_pkg::*;
	import cache_types_pkg::*;
(
	input  logic      CLK,
	input  logic      nRST,
	input  cpu_req_t  cpu_req,
	output cpu_resp_t cpu_resp,
	output mem_req_t  mem_req,
	input  mem_resp_t mem_resp
);

	// data array holds every way of every set
	localparam int DATA_DEPTH = WAYS * SETS;

	dcache_addr_t       req_addr;
	lookup_t            lookup;
	tag_entry_t         flush_entry;
	logic [INDEX_W:0]   flush_slot;
	logic               tag_we;
	logic               tag_way;
	logic [INDEX_W-1:0] tag_index;
	tag_entry_t         tag_wdata;
	logic               lru_touch;
	logic               lru_way;
	logic               data_we;
	logic [INDEX_W:0]   data_addr;
	block_t             data_wdata;
	block_t             data_rdata;

	assign req_addr = cpu_req.addr;

	dcache_ctrl u_ctrl (
		.CLK         (CLK),
		.nRST        (nRST),
		.req         (cpu_req),
		.resp        (cpu_resp),
		.mem_req     (mem_req),
		.mem_resp    (mem_resp),
		.lookup      (lookup),
		.flush_entry (flush_entry),
		.flush_slot  (flush_slot),
		.tag_we      (tag_we),
		.tag_way     (tag_way),
		.tag_index   (tag_index),
		.tag_wdata   (tag_wdata),
		.lru_touch   (lru_touch),
		.lru_way     (lru_way),
		.data_we     (data_we),
		.data_addr   (data_addr),
		.data_wdata  (data_wdata),
		.data_rdata  (data_rdata)
	);

	tag_lookup u_tags (
		.CLK         (CLK),
		.nRST        (nRST),
		.addr        (req_addr),
		.flush_slot  (flush_slot),
		.tag_we      (tag_we),
		.tag_way     (tag_way),
		.tag_index   (tag_index),
		.tag_wdata   (tag_wdata),
		.lru_touch   (lru_touch),
		.lru_way     (lru_way),
		.lookup      (lookup),
		.flush_entry (flush_entry)
	);

	// addressed as {way, index}
	cache_ram #(
		.entry_t (block_t),
		.DEPTH   (DATA_DEPTH)
	) u_data (
		.CLK   (CLK),
		.nRST  (nRST),
		.we    (data_we),
		.waddr (data_addr),
		.wdata (data_wdata),
		.raddr (data_addr),
		.rdata (data_rdata)
	);

endmodule

`default_nettype wire

/* verilog/dcache_ctrl.sv */
// data cache controller
// FSM for hits, dirty write-back, block fetch and halt flush;
// drives tag, LRU and data array writes and memory transfers
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
	import cpu_types_pkg::*;
	import cache_types_pkg::*;
(
	input  logic               CLK,
	input  logic               nRST,
	input  cpu_req_t           req,
	output cpu_resp_t          resp,
	output mem_req_t           mem_req,
	input  mem_resp_t          mem_resp,
	input  lookup_t            lookup,
	input  tag_entry_t         flush_entry,
	output logic [INDEX_W:0]   flush_slot,
	output logic               tag_we,
	output logic               tag_way,
	output logic [INDEX_W-1:0] tag_index,
	output tag_entry_t         tag_wdata,
	output logic               lru_touch,
	output logic               lru_way,
	output logic               data_we,
	output logic [INDEX_W:0]   data_addr,
	output block_t             data_wdata,
	input  block_t             data_rdata
);

	ctrl_state_t      state;
	ctrl_state_t      next_state;
	dcache_addr_t     addr;
	logic             access;
	logic             flushing;
	logic             second;
	logic             victim_way;
	logic [INDEX_W:0] slot;
	block_t           fill_blk;

	function automatic block_t merge_word(block_t blk, logic off, word_t w);
		block_t merged;
		merged = blk;
		merged.words[off] = w;
		return merged;
	endfunction

	assign addr     = req.addr;
	assign access   = req.ren | req.wen;
	assign flushing = state inside {FLUSH1, FLUSH2, FLUSH_NEXT, FLUSHED};
	// second word of a block transfer
	assign second   = state inside {WB2, FETCH2, FLUSH2};

	// tag arrays read at the cursor while flushing
	assign flush_slot = flushing ? slot : {1'b0, addr.index};

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state      <= IDLE;
			victim_way <= 1'b0;
			slot       <= '0;
		end else begin
			state <= next_state;
			// victim is fixed for the whole miss
			if (state == IDLE && access && !req.halt && !lookup.hit) begin
				victim_way <= lookup.victim_way;
			end
			if (state == FLUSH_NEXT && slot != '1) begin
				slot <= slot + 1'b1;
			end
		end
	end

	// fetched words gather here until FILL
	always_ff @(posedge CLK) begin
		if (!mem_resp.dwait && state == FETCH1) begin
			fill_blk.words[0] <= mem_resp.load;
		end
		if (!mem_resp.dwait && state == FETCH2) begin
			fill_blk.words[1] <= mem_resp.load;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (req.halt) begin
					next_state = FLUSH1;
				end else if (access && !lookup.hit) begin
					if (lookup.victim.valid && lookup.victim.dirty) begin
						next_state = WB1;
					end else begin
						next_state = FETCH1;
					end
				end
			end
			WB1:    next_state = mem_resp.dwait ? WB1 : WB2;
			WB2:    next_state = mem_resp.dwait ? WB2 : FETCH1;
			FETCH1: next_state = mem_resp.dwait ? FETCH1 : FETCH2;
			FETCH2: next_state = mem_resp.dwait ? FETCH2 : FILL;
			FILL:   next_state = IDLE;
			FLUSH1: begin
				// clean or empty slots are skipped
				if (!(flush_entry.valid && flush_entry.dirty)) begin
					next_state = FLUSH_NEXT;
				end else if (!mem_resp.dwait) begin
					next_state = FLUSH2;
				end
			end
			FLUSH2:     next_state = mem_resp.dwait ? FLUSH2 : FLUSH_NEXT;
			FLUSH_NEXT: next_state = (slot == '1) ? FLUSHED : FLUSH1;
			FLUSHED:    next_state = FLUSHED;
			default:    next_state = IDLE;
		endcase
	end

	always_comb begin
		resp         = '0;
		resp.flushed = (state == FLUSHED);
		mem_req      = '0;
		tag_we       = 1'b0;
		tag_way      = lookup.hit_way;
		tag_index    = addr.index;
		tag_wdata    = '0;
		lru_touch    = 1'b0;
		lru_way      = lookup.hit_way;
		data_we      = 1'b0;
		data_addr    = {lookup.hit_way, addr.index};
		data_wdata   = data_rdata;

		case (state)
			IDLE: begin
				if (access && !req.halt && lookup.hit) begin
					resp.dhit = 1'b1;
					resp.load = data_rdata.words[addr.blkoff];
					lru_touch = 1'b1;
					if (req.wen) begin
						data_we         = 1'b1;
						data_wdata      = merge_word(data_rdata, addr.blkoff, req.store);
						tag_we          = 1'b1;
						tag_wdata.tag   = addr.tag;
						tag_wdata.valid = 1'b1;
						tag_wdata.dirty = 1'b1;
					end
				end
			end
			WB1, WB2: begin
				data_addr     = {victim_way, addr.index};
				mem_req.wen   = 1'b1;
				mem_req.addr  = {lookup.entries[victim_way].tag, addr.index, second, 2'b00};
				mem_req.store = data_rdata.words[second];
			end
			FETCH1, FETCH2: begin
				mem_req.ren  = 1'b1;
				mem_req.addr = {addr.tag, addr.index, second, 2'b00};
			end
			FILL: begin
				resp.dhit       = 1'b1;
				resp.load       = fill_blk.words[addr.blkoff];
				data_addr       = {victim_way, addr.index};
				data_we         = 1'b1;
				data_wdata      = req.wen ? merge_word(fill_blk, addr.blkoff, req.store)
				                          : fill_blk;
				tag_we          = 1'b1;
				tag_way         = victim_way;
				tag_wdata.tag   = addr.tag;
				tag_wdata.valid = 1'b1;
				tag_wdata.dirty = req.wen;
				lru_touch       = 1'b1;
				lru_way         = victim_way;
			end
			FLUSH1, FLUSH2: begin
				data_addr     = slot;
				mem_req.wen   = flush_entry.valid && flush_entry.dirty;
				mem_req.addr  = {flush_entry.tag, slot[INDEX_W-1:0], second, 2'b00};
				mem_req.store = data_rdata.words[second];
				// slot goes clean once its second word is taken
				if (state == FLUSH2 && !mem_resp.dwait) begin
					tag_we          = 1'b1;
					tag_way         = slot[INDEX_W];
					tag_index       = slot[INDEX_W-1:0];
					tag_wdata       = flush_entry;
					tag_wdata.dirty = 1'b0;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/tag_lookup.sv */
// tag side of the two-way data cache
// holds the tag entries and per-set LRU bits, compares the
// address tag against both ways and picks the victim way
`timescale 1ns/1ps
`default_nettype none

module tag_lookup
	import cpu_types_pkg::*;
	import cache_types_pkg::*;
(
	input  logic               CLK,
	input  logic               nRST,
	input  dcache_addr_t       addr,
	input  logic [INDEX_W:0]   flush_slot,
	input  logic               tag_we,
	input  logic               tag_way,
	input  logic [INDEX_W-1:0] tag_index,
	input  tag_entry_t         tag_wdata,
	input  logic               lru_touch,
	input  logic               lru_way,
	output lookup_t            lookup,
	output tag_entry_t         flush_entry
);

	tag_entry_t [WAYS-1:0] entries;
	logic [WAYS-1:0]       match;
	// one bit per set, the most recently used way
	logic [SETS-1:0]       lru;
	logic                  victim_way;

	for (genvar w = 0; w < WAYS; w++) begin : g_way
		cache_ram #(
			.entry_t (tag_entry_t),
			.DEPTH   (SETS)
		) u_tags (
			.CLK   (CLK),
			.nRST  (nRST),
			.we    (tag_we && (tag_way == 1'(w))),
			.waddr (tag_index),
			.wdata (tag_wdata),
			.raddr (flush_slot[INDEX_W-1:0]),
			.rdata (entries[w])
		);

		assign match[w] = entries[w].valid && (entries[w].tag == addr.tag);
	end

	// invalid way first, else the least recently used one
	always_comb begin
		if (!entries[0].valid) begin
			victim_way = 1'b0;
		end else if (!entries[1].valid) begin
			victim_way = 1'b1;
		end else begin
			victim_way = ~lru[addr.index];
		end
	end

	always_comb begin
		lookup.hit        = |match;
		lookup.hit_way    = match[1];
		lookup.victim_way = victim_way;
		lookup.victim     = entries[victim_way];
		lookup.entries    = entries;
	end

	// set comes from the flush cursor and the way from its top bit
	assign flush_entry = entries[flush_slot[INDEX_W]];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lru <= '0;
		end else if (lru_touch) begin
			lru[addr.index] <= lru_way;
		end
	end

endmodule

`default_nettype wire

/* verilog/cache_ram.sv */
// generic storage array for the cache
// one synchronous write port, one combinational read port,
// contents cleared to zero on reset
`timescale 1ns/1ps
`default_nettype none

module cache_ram #(
	parameter type entry_t = logic,
	parameter int  DEPTH   = 8
) (
	input  logic                     CLK,
	input  logic                     nRST,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  entry_t                   wdata,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	output entry_t                   rdata
);

	entry_t mem [DEPTH];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			// cleared so tag entries come up invalid
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// combinational read for same-cycle lookup
	assign rdata = mem[raddr];

endmodule

`default_nettype wire

/* verilog/cache_types_pkg.sv */
// data cache port and storage types
// core and memory request/response structs, tag entries,
// data blocks, lookup result and controller states
`default_nettype none

package cache_types_pkg;
	import cpu_types_pkg::*;

	// core to cache
	typedef struct packed {
		logic  ren;
		logic  wen;
		logic  halt;
		addr_t addr;
		word_t store;
	} cpu_req_t;

	// cache to core
	typedef struct packed {
		logic  dhit;
		word_t load;
		logic  flushed;
	} cpu_resp_t;

	// cache to memory with one word per transfer
	typedef struct packed {
		logic  ren;
		logic  wen;
		addr_t addr;
		word_t store;
	} mem_req_t;

	typedef struct packed {
		logic  dwait;
		word_t load;
	} mem_resp_t;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic             valid;
		logic             dirty;
	} tag_entry_t;

	// words[0] sits at block offset 0
	typedef struct packed {
		word_t [1:0] words;
	} block_t;

	typedef struct packed {
		logic                   hit;
		logic                   hit_way;
		logic                   victim_way;
		tag_entry_t             victim;
		tag_entry_t [WAYS-1:0]  entries;
	} lookup_t;

	typedef enum logic [3:0] {
		IDLE,
		WB1,
		WB2,
		FETCH1,
		FETCH2,
		FILL,
		FLUSH1,
		FLUSH2,
		FLUSH_NEXT,
		FLUSHED
	} ctrl_state_t;

endpackage

`default_nettype wire

/* verilog/cpu_types_pkg.sv */
// core-side types for the data cache
// word and address widths, cache geometry and the
// tag / index / offset split of a data address
`default_nettype none

package cpu_types_pkg;

	// word and byte address
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;

	// two-way, eight sets, two words per block
	parameter int WAYS    = 2;
	parameter int SETS    = 8;
	parameter int INDEX_W = 3;
	parameter int BLKOFF_W = 1;
	parameter int BYTOFF_W = 2;
	parameter int TAG_W   = 32 - INDEX_W - BLKOFF_W - BYTOFF_W;

	// address as the cache sees it
	typedef struct packed {
		logic [TAG_W-1:0]    tag;
		logic [INDEX_W-1:0]  index;
		logic [BLKOFF_W-1:0] blkoff;
		logic [BYTOFF_W-1:0] bytoff;
	} dcache_addr_t;

endpackage

`default_nettype wire
